// File: verilog/graph_pkg.sv
package graph_pkg;

    // graph capacity
    localparam int max_nodes = 64;
    localparam int node_width = 6;

    // edge store capacity, also the widest successor list
    localparam int max_edges = 256;
    localparam int edge_width = 8;

    // path counts wrap modulo 2^16
    localparam int result_width = 16;

    typedef logic [node_width-1:0] node_t;

    typedef logic [edge_width-1:0] edge_idx_t;

    typedef logic [result_width-1:0] path_count_t;

endpackage

// File: verilog/host_pkg.sv
package host_pkg;

    localparam int wb_data_width = 32;
    localparam int wb_addr_width = 3;

    // word addresses
    localparam logic [wb_addr_width-1:0] reg_edge = 3'd0;
    localparam logic [wb_addr_width-1:0] reg_endpoints = 3'd1;
    localparam logic [wb_addr_width-1:0] reg_order = 3'd2;
    localparam logic [wb_addr_width-1:0] reg_control = 3'd3;
    localparam logic [wb_addr_width-1:0] reg_status = 3'd4;

    // field positions
    localparam int edge_dst_lsb = 0;
    localparam int edge_src_lsb = 8;
    localparam int edge_new_src_bit = 16;
    localparam int ep_start_lsb = 0;
    localparam int ep_end_lsb = 8;
    localparam int order_node_lsb = 0;
    localparam int ctrl_decoding_done_bit = 0;
    localparam int ctrl_order_done_bit = 1;
    localparam int status_valid_bit = 31;
    localparam int status_result_lsb = 0;

endpackage

// File: verilog/adj_query_if.sv
`timescale 1ns/100ps

interface adj_query_if
    import graph_pkg::*;
();

    // query channel
    logic  query_valid;
    logic  query_ready;
    node_t query_node;

    // reply burst, one beat per successor
    logic  reply_valid;
    logic  reply_ready;
    node_t reply_node;
    logic  reply_last;
    logic  reply_no_edges;

    modport requester (
        output query_valid,
        output query_node,
        output reply_ready,
        input  query_ready,
        input  reply_valid,
        input  reply_node,
        input  reply_last,
        input  reply_no_edges
    );

    modport responder (
        input  query_valid,
        input  query_node,
        input  reply_ready,
        output query_ready,
        output reply_valid,
        output reply_node,
        output reply_last,
        output reply_no_edges
    );

endinterface

// File: verilog/adjacency_map.sv
`timescale 1ns/100ps

module adjacency_map
    import graph_pkg::*;
(
    input  logic  clk,
    input  logic  rst_n,
    input  logic  edge_valid,
    input  logic  new_src,
    input  node_t src_node,
    input  node_t dst_node,
    input  logic  decoding_done,
    adj_query_if.responder q
);

    typedef enum logic [1:0] {
        s_idle,
        s_fetch,
        s_reply
    } state_t;

    state_t state;

    node_t     edge_mem [max_edges];
    edge_idx_t off_tab [max_nodes];
    edge_idx_t len_tab [max_nodes];
    logic [max_nodes-1:0] has_group;

    edge_idx_t tail;
    edge_idx_t group_len;
    edge_idx_t rd_ptr;
    edge_idx_t rd_left;

    logic load;
    logic accept;
    logic fetch;

    assign load = edge_valid && !decoding_done;
    assign accept = q.query_valid && q.query_ready;

    // next edge is read when entering the burst or when a non-final beat leaves
    assign fetch = (state == s_fetch) ||
                   ((state == s_reply) && q.reply_valid && q.reply_ready && !q.reply_last);

    always_ff @(posedge clk) begin
        if (load) begin
            edge_mem[tail] <= dst_node;
            if (new_src) begin
                off_tab[src_node] <= tail;
                len_tab[src_node] <= edge_idx_t'(1);
            end else begin
                len_tab[src_node] <= group_len + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            tail <= '0;
            group_len <= '0;
            has_group <= '0;
        end else if (load) begin
            tail <= tail + 1'b1;
            if (new_src) begin
                group_len <= edge_idx_t'(1);
                has_group[src_node] <= 1'b1;
            end else begin
                group_len <= group_len + 1'b1;
            end
        end
    end

    // ready comes a cycle after the request, only once loading has closed
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= s_idle;
            q.query_ready <= 1'b0;
            q.reply_valid <= 1'b0;
        end else begin
            q.query_ready <= (state == s_idle) && decoding_done && q.query_valid && !accept;
            case (state)
                s_idle: begin
                    if (accept) begin
                        state <= s_fetch;
                    end
                end
                s_fetch: begin
                    q.reply_valid <= 1'b1;
                    state <= s_reply;
                end
                s_reply: begin
                    if (q.reply_valid && q.reply_ready && q.reply_last) begin
                        q.reply_valid <= 1'b0;
                        state <= s_idle;
                    end
                end
                default: state <= s_idle;
            endcase
        end
    end

    // table read on acceptance, then one edge read per beat
    always_ff @(posedge clk) begin
        if (accept) begin
            rd_ptr <= off_tab[q.query_node];
            rd_left <= has_group[q.query_node] ? len_tab[q.query_node] : '0;
        end else if (fetch) begin
            q.reply_node <= edge_mem[rd_ptr];
            q.reply_last <= (rd_left <= edge_idx_t'(1));
            q.reply_no_edges <= (rd_left == '0);
            if (rd_left != '0) begin
                rd_ptr <= rd_ptr + 1'b1;
                rd_left <= rd_left - 1'b1;
            end
        end
    end

endmodule

// File: verilog/node_path_counter.sv
`timescale 1ns/100ps

module node_path_counter
    import graph_pkg::*;
(
    input  logic        clk,
    input  logic        rst_n,
    input  logic        start_end_valid,
    input  node_t       start_node,
    input  node_t       end_node,
    input  logic        order_valid,
    input  node_t       order_node,
    input  logic        order_done,
    output logic        order_ready,
    output logic        result_valid,
    output path_count_t result_value,
    adj_query_if.requester q
);

    typedef enum logic [1:0] {
        s_idle,
        s_query,
        s_walk,
        s_done
    } state_t;

    state_t state;

    path_count_t cnt_mem [max_nodes];
    logic [max_nodes-1:0] cnt_set;

    node_t       end_idx;
    path_count_t src_cnt;
    logic        done_req;

    path_count_t order_cnt;
    path_count_t succ_cnt;
    path_count_t end_cnt;

    logic        order_take;
    logic        beat;
    logic        finish;
    logic        wr_en;
    node_t       wr_addr;
    path_count_t wr_data;

    // entries never written read as zero
    assign order_cnt = cnt_set[order_node] ? cnt_mem[order_node] : '0;
    assign succ_cnt = cnt_set[q.reply_node] ? cnt_mem[q.reply_node] : '0;
    assign end_cnt = cnt_set[end_idx] ? cnt_mem[end_idx] : '0;

    assign order_ready = (state == s_idle) && !done_req;
    assign order_take = order_valid && order_ready;
    assign q.reply_ready = (state == s_walk);
    assign beat = q.reply_valid && q.reply_ready;
    assign finish = (state == s_idle) && done_req;

    // single write port shared by start seeding and edge propagation
    always_comb begin
        wr_en = 1'b0;
        wr_addr = start_node;
        wr_data = path_count_t'(1);
        if (start_end_valid) begin
            wr_en = 1'b1;
        end else if (beat && !q.reply_no_edges) begin
            wr_en = 1'b1;
            wr_addr = q.reply_node;
            wr_data = succ_cnt + src_cnt;
        end
    end

    always_ff @(posedge clk) begin
        if (wr_en) begin
            cnt_mem[wr_addr] <= wr_data;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            cnt_set <= '0;
        end else if (wr_en) begin
            cnt_set[wr_addr] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= s_idle;
            q.query_valid <= 1'b0;
            done_req <= 1'b0;
            result_valid <= 1'b0;
        end else begin
            if (order_done) begin
                done_req <= 1'b1;
            end
            case (state)
                s_idle: begin
                    if (finish) begin
                        result_valid <= 1'b1;
                        state <= s_done;
                    end else if (order_take) begin
                        q.query_valid <= 1'b1;
                        state <= s_query;
                    end
                end
                s_query: begin
                    if (q.query_ready) begin
                        q.query_valid <= 1'b0;
                        state <= s_walk;
                    end
                end
                s_walk: begin
                    if (beat && q.reply_last) begin
                        state <= s_idle;
                    end
                end
                // result held until reset
                s_done: state <= s_done;
                default: state <= s_idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (start_end_valid) begin
            end_idx <= end_node;
        end
        if (order_take) begin
            src_cnt <= order_cnt;
            q.query_node <= order_node;
        end
        if (finish) begin
            result_value <= end_cnt;
        end
    end

endmodule

// File: verilog/wb_graph_host.sv
`timescale 1ns/100ps

module wb_graph_host
    import graph_pkg::*;
    import host_pkg::*;
(
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     wb_cyc,
    input  logic                     wb_stb,
    input  logic                     wb_we,
    input  logic [wb_addr_width-1:0] wb_adr,
    input  logic [wb_data_width-1:0] wb_dat_w,
    input  logic                     order_ready,
    input  logic                     result_valid,
    input  path_count_t              result_value,
    output logic [wb_data_width-1:0] wb_dat_r,
    output logic                     wb_ack,
    output logic                     edge_valid,
    output logic                     new_src,
    output node_t                    src_node,
    output node_t                    dst_node,
    output logic                     decoding_done,
    output logic                     start_end_valid,
    output node_t                    start_node,
    output node_t                    end_node,
    output logic                     order_valid,
    output node_t                    order_node,
    output logic                     order_done
);

    logic ack_q;
    logic req;
    logic ctrl_wr;
    logic order_wr;
    logic order_take;
    logic [wb_data_width-1:0] status_word;

    // no new access is taken while acking or while an order node waits
    assign req = wb_cyc && wb_stb && !ack_q && !order_valid;
    assign ctrl_wr = req && wb_we && (wb_adr == reg_control);
    assign order_wr = req && wb_we && (wb_adr == reg_order);
    assign order_take = order_valid && order_ready;
    assign wb_ack = ack_q && wb_cyc && wb_stb;

    always_comb begin
        status_word = '0;
        status_word[status_valid_bit] = result_valid;
        status_word[status_result_lsb +: result_width] = result_value;
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            ack_q <= 1'b0;
            edge_valid <= 1'b0;
            start_end_valid <= 1'b0;
            decoding_done <= 1'b0;
            order_valid <= 1'b0;
            order_done <= 1'b0;
        end else begin
            // order writes ack once the counter takes the node
            ack_q <= (req && !order_wr) || order_take;
            edge_valid <= req && wb_we && (wb_adr == reg_edge);
            start_end_valid <= req && wb_we && (wb_adr == reg_endpoints);
            order_done <= ctrl_wr && wb_dat_w[ctrl_order_done_bit];
            if (ctrl_wr && wb_dat_w[ctrl_decoding_done_bit]) begin
                decoding_done <= 1'b1;
            end
            if (order_wr) begin
                order_valid <= 1'b1;
            end else if (order_take) begin
                order_valid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (req && wb_we) begin
            case (wb_adr)
                reg_edge: begin
                    dst_node <= wb_dat_w[edge_dst_lsb +: node_width];
                    src_node <= wb_dat_w[edge_src_lsb +: node_width];
                    new_src <= wb_dat_w[edge_new_src_bit];
                end
                reg_endpoints: begin
                    start_node <= wb_dat_w[ep_start_lsb +: node_width];
                    end_node <= wb_dat_w[ep_end_lsb +: node_width];
                end
                reg_order: order_node <= wb_dat_w[order_node_lsb +: node_width];
                default: ;
            endcase
        end
        // write-only registers read back as zero
        if (req && !wb_we) begin
            wb_dat_r <= (wb_adr == reg_status) ? status_word : '0;
        end
    end

endmodule

// File: verilog/path_count_top.sv
`timescale 1ns/100ps

module path_count_top
    import graph_pkg::*;
    import host_pkg::*;
(
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     wb_cyc,
    input  logic                     wb_stb,
    input  logic                     wb_we,
    input  logic [wb_addr_width-1:0] wb_adr,
    input  logic [wb_data_width-1:0] wb_dat_w,
    output logic [wb_data_width-1:0] wb_dat_r,
    output logic                     wb_ack
);

    logic        edge_valid;
    logic        new_src;
    node_t       src_node;
    node_t       dst_node;
    logic        decoding_done;
    logic        start_end_valid;
    node_t       start_node;
    node_t       end_node;
    logic        order_valid;
    logic        order_ready;
    node_t       order_node;
    logic        order_done;
    logic        result_valid;
    path_count_t result_value;

    adj_query_if q_if ();

    // register map to strobes
    wb_graph_host wb_graph_host_i (
        .*
    );

    adjacency_map adjacency_map_i (
        .*,
        .q (q_if.responder)
    );

    node_path_counter node_path_counter_i (
        .*,
        .q (q_if.requester)
    );

endmodule

// File: verif/path_count_chk.sv
`timescale 1ns/100ps

module path_count_chk
    import graph_pkg::*;
(
    input logic        clk,
    input logic        rst_n,
    input logic        wb_cyc,
    input logic        wb_stb,
    input logic        wb_ack,
    input logic        result_valid,
    input path_count_t result_value
);

    int fail_count = 0;

    // ack belongs to a live strobe
    ack_in_strobe: assert property (@(posedge clk) wb_ack |-> (wb_cyc && wb_stb))
        else begin
            fail_count++;
            $error("wb_ack high without wb_cyc and wb_stb");
        end

    ack_single: assert property (@(posedge clk) (rst_n && wb_ack) |=> !wb_ack)
        else begin
            fail_count++;
            $error("wb_ack high for two consecutive cycles");
        end

    ack_after_reset: assert property (@(posedge clk) !rst_n |=> !wb_ack)
        else begin
            fail_count++;
            $error("wb_ack high in the first cycle after reset");
        end

    // result is final once valid
    result_hold: assert property (@(posedge clk)
        (rst_n && result_valid) |=> (!rst_n || (result_valid && $stable(result_value))))
        else begin
            fail_count++;
            $error("result changed or lost valid before reset");
        end

endmodule

// File: verif/path_count_tb.sv
`timescale 1ns/100ps

module path_count_tb
    import graph_pkg::*;
    import host_pkg::*;
();

    localparam int clk_period = 100;
    localparam int ack_limit = 64;
    localparam int poll_limit = 32;

    logic clk;
    logic rst_n;
    logic wb_cyc;
    logic wb_stb;
    logic wb_we;
    logic [wb_addr_width-1:0] wb_adr;
    logic [wb_data_width-1:0] wb_dat_w;
    logic [wb_data_width-1:0] wb_dat_r;
    logic wb_ack;

    logic [15:0] lfsr;
    int result_errors;
    int bus_errors;
    int protocol_errors;

    // graph under test with edges grouped by source
    node_t e_src [max_edges];
    node_t e_dst [max_edges];
    int    n_edges;
    int    n_nodes;
    node_t start_n;
    node_t end_n;

    path_count_top path_count_top_i (.*);

    bind path_count_top path_count_chk path_count_chk_i (
        .clk          (clk),
        .rst_n        (rst_n),
        .wb_cyc       (wb_cyc),
        .wb_stb       (wb_stb),
        .wb_ack       (wb_ack),
        .result_valid (result_valid),
        .result_value (result_value)
    );

    initial begin
        clk = 1'b0;
        forever #(clk_period / 2) clk = ~clk;
    end

    // x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    function automatic int take_bits(input int n);
        int v;
        v = 0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_next(lfsr);
            v = (v << 1) | int'(lfsr[0]);
        end
        return v;
    endfunction

    // rough bound from bus accesses, one query per node, one beat per edge and status polls
    function automatic int test_cycles(input int nodes, input int edges);
        return 8 + 4 * edges + 10 * nodes + 4 * poll_limit;
    endfunction

    function automatic void add_edge(input int s, input int d);
        if (n_edges < max_edges) begin
            e_src[n_edges] = node_t'(s);
            e_dst[n_edges] = node_t'(d);
            n_edges++;
        end
    endfunction

    function automatic void build_chain(input int len, input int s, input int t);
        n_edges = 0;
        n_nodes = len;
        for (int i = 0; i < len - 1; i++) begin
            add_edge(i, i + 1);
        end
        start_n = node_t'(s);
        end_n = node_t'(t);
    endfunction

    // end node cut off and most nodes without successors
    function automatic void build_sparse();
        n_edges = 0;
        n_nodes = 8;
        add_edge(0, 1);
        add_edge(0, 3);
        add_edge(1, 3);
        add_edge(4, 5);
        start_n = node_t'(0);
        end_n = node_t'(5);
    endfunction

    function automatic void build_random(input int nodes);
        int deg;
        n_edges = 0;
        n_nodes = nodes;
        for (int s = 0; s < nodes - 1; s++) begin
            deg = take_bits(2);
            if (take_bits(3) == 0) begin
                deg = 12;
            end
            for (int k = 0; k < deg; k++) begin
                add_edge(s, s + 1 + take_bits(6) % (nodes - 1 - s));
            end
        end
        start_n = node_t'(take_bits(3));
        end_n = node_t'(nodes - 1 - take_bits(2));
    endfunction

    // 17 diamonds in a row give 2^17 paths from 0 to 51
    function automatic void build_diamonds(input logic side);
        n_edges = 0;
        n_nodes = 52;
        for (int n = 0; n < 52; n++) begin
            if (n % 3 == 0 && n < 51) begin
                add_edge(n, n + 1);
                add_edge(n, n + 2);
            end else if (n % 3 == 1) begin
                add_edge(n, n + 2);
            end else if (n % 3 == 2) begin
                add_edge(n, n + 1);
            end
            if (side && n == 1) begin
                add_edge(1, 50);
            end
        end
        start_n = node_t'(0);
        end_n = node_t'(51);
    endfunction

    // paths by dynamic programming over ascending node order
    function automatic path_count_t ref_count();
        path_count_t cnt [max_nodes];
        for (int n = 0; n < max_nodes; n++) begin
            cnt[n] = '0;
        end
        cnt[start_n] = path_count_t'(1);
        for (int n = 0; n < n_nodes; n++) begin
            for (int e = 0; e < n_edges; e++) begin
                if (int'(e_src[e]) == n) begin
                    cnt[e_dst[e]] = cnt[e_dst[e]] + cnt[n];
                end
            end
        end
        return cnt[end_n];
    endfunction

    task automatic apply_reset();
        @(posedge clk);
        rst_n <= 1'b0;
        repeat (2) @(posedge clk);
        rst_n <= 1'b1;
    endtask

    task automatic wb_access(input logic we, input logic [wb_addr_width-1:0] adr,
                             input logic [wb_data_width-1:0] wdata,
                             output logic [wb_data_width-1:0] rdata);
        int   waited;
        logic got_ack;
        waited = 0;
        @(posedge clk);
        wb_cyc <= 1'b1;
        wb_stb <= 1'b1;
        wb_we <= we;
        wb_adr <= adr;
        wb_dat_w <= wdata;
        do begin
            @(posedge clk);
            waited++;
        end while (!wb_ack && waited < ack_limit);
        got_ack = wb_ack;
        rdata = wb_dat_r;
        wb_cyc <= 1'b0;
        wb_stb <= 1'b0;
        wb_we <= 1'b0;
        assert (got_ack) else begin
            bus_errors++;
            $display("no wb_ack within %0d cycles for address %0d", ack_limit, adr);
        end
    endtask

    task automatic wb_write(input logic [wb_addr_width-1:0] adr,
                            input logic [wb_data_width-1:0] data);
        logic [wb_data_width-1:0] unused;
        wb_access(1'b1, adr, data, unused);
    endtask

    task automatic wb_read(input logic [wb_addr_width-1:0] adr,
                           output logic [wb_data_width-1:0] data);
        wb_access(1'b0, adr, '0, data);
    endtask

    task automatic run_graph(input string label);
        logic [wb_data_width-1:0] w;
        logic [wb_data_width-1:0] rd;
        path_count_t exp;
        path_count_t got;
        int polls;
        apply_reset();
        for (int e = 0; e < n_edges; e++) begin
            w = '0;
            w[edge_dst_lsb +: node_width] = e_dst[e];
            w[edge_src_lsb +: node_width] = e_src[e];
            w[edge_new_src_bit] = 1'b1;
            if (e > 0) begin
                w[edge_new_src_bit] = (e_src[e] != e_src[e - 1]);
            end
            wb_write(reg_edge, w);
        end
        w = '0;
        w[ep_start_lsb +: node_width] = start_n;
        w[ep_end_lsb +: node_width] = end_n;
        wb_write(reg_endpoints, w);
        w = '0;
        w[ctrl_decoding_done_bit] = 1'b1;
        wb_write(reg_control, w);
        // ascending order is topological for these graphs
        for (int n = 0; n < n_nodes; n++) begin
            w = '0;
            w[order_node_lsb +: node_width] = node_t'(n);
            wb_write(reg_order, w);
        end
        w = '0;
        w[ctrl_order_done_bit] = 1'b1;
        wb_write(reg_control, w);
        polls = 0;
        do begin
            wb_read(reg_status, rd);
            polls++;
        end while (!rd[status_valid_bit] && polls < poll_limit);
        assert (rd[status_valid_bit]) else begin
            bus_errors++;
            $display("%s: status never showed a valid result", label);
        end
        if (rd[status_valid_bit]) begin
            exp = ref_count();
            got = rd[status_result_lsb +: result_width];
            assert (got == exp) else begin
                result_errors++;
                $display("ERROR %0t: %s expected %0d got %0d", $time, label, exp, got);
            end
        end
    endtask

    initial begin
        rst_n = 1'b0;
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        wb_we = 1'b0;
        wb_adr = '0;
        wb_dat_w = '0;
        lfsr = 16'd18097;
        result_errors = 0;
        bus_errors = 0;
        protocol_errors = 0;
        apply_reset();
        build_chain(10, 0, 9);
        run_graph("chain");
        build_chain(10, 4, 4);
        run_graph("start equals end");
        build_chain(10, 5, 2);
        run_graph("unreachable end");
        build_sparse();
        run_graph("sparse graph");
        for (int g = 0; g < 3; g++) begin
            build_random(40);
            run_graph("random dag");
        end
        build_diamonds(1'b0);
        run_graph("diamonds");
        build_diamonds(1'b1);
        run_graph("diamonds with side edge");
        protocol_errors = path_count_top_i.path_count_chk_i.fail_count;
        $display("errors: %0d result, %0d bus, %0d protocol",
                 result_errors, bus_errors, protocol_errors);
        if (result_errors + bus_errors + protocol_errors == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

    initial begin
        int limit;
        limit = 4 * (3 * test_cycles(10, 9) + test_cycles(8, 4) +
                     3 * test_cycles(40, max_edges) + 2 * test_cycles(52, 69));
        repeat (limit) @(posedge clk);
        $display("watchdog expired after %0d cycles", limit);
        $display("TEST FAILED");
        $finish;
    end

endmodule

// File: tb.f
verilog/graph_pkg.sv
verilog/host_pkg.sv
verilog/adj_query_if.sv
verilog/adjacency_map.sv
verilog/node_path_counter.sv
verilog/wb_graph_host.sv
verilog/path_count_top.sv
verif/path_count_chk.sv
verif/path_count_tb.sv

// File: run.sh
#!/bin/sh
rm -f sim.log
verilator --binary --timing --assert -f tb.f --top-module path_count_tb -o path_count_sim &&
./obj_dir/path_count_sim > sim.log 2>&1 ||
echo "simulation did not complete" >> sim.log
cat sim.log
! grep -q "TEST FAILED" sim.log && grep -q "TEST PASSED" sim.log
